// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ccu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/ccu_addr_min.sv ====
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_addr_min (
    input  ccu_pkg::isa_addr_t rd_ptr_i [`CCU_NUM_ENG],
    output ccu_pkg::isa_addr_t min_o
);
    import ccu_pkg::*;

    localparam int LVL   = $clog2(`CCU_NUM_ENG);
    localparam int LEAFS = 1 << LVL;

    // Heap order, node i has children 2i+1 and 2i+2
    isa_addr_t node [2*LEAFS-1];

    for (genvar g = 0; g < LEAFS; g++) begin : g_leaf
        if (g < `CCU_NUM_ENG) begin : g_used
            assign node[LEAFS-1+g] = rd_ptr_i[g];
        end else begin : g_pad
            assign node[LEAFS-1+g] = '1;   // Never the minimum
        end
    end

    for (genvar i = 0; i < LEAFS-1; i++) begin : g_cmp
        assign node[i] = (node[2*i+1] < node[2*i+2]) ? node[2*i+1] : node[2*i+2];
    end

    // Everything below this address has been read by every engine
    assign min_o = node[0];

endmodule

// ==== design/ccu_consts.svh ====
`ifndef CCU_CONSTS_SVH
`define CCU_CONSTS_SVH

// ======================================
// Instruction word layout
// ======================================
`define CCU_WORD_W      64
`define CCU_OPC_W       8
`define CCU_MODE_W      8
`define CCU_LAYER_W     16
`define CCU_PAYLOAD_W   (`CCU_WORD_W - `CCU_OPC_W)
`define CCU_HDR_RSV_W   (`CCU_WORD_W - `CCU_OPC_W - `CCU_MODE_W - `CCU_LAYER_W)

// Instruction RAM address
`define CCU_ADDR_W      12

// ======================================
// Engine array
// ======================================
`define CCU_NUM_ENG     4     // Opcodes 1 .. CCU_NUM_ENG
`define CCU_CFG_WORDS   2     // Payload words per configuration

`endif

// ==== design/ccu_fetch.sv ====
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    // Instruction RAM
    output ccu_pkg::isa_addr_t        isa_addr_o,
    output logic                      isa_addr_vld_o,
    input  logic                      isa_addr_rdy_i,
    input  ccu_pkg::isa_word_u        isa_dat_i,
    input  logic                      isa_dat_vld_i,
    output logic                      isa_dat_rdy_o,
    // Slot array
    input  logic [`CCU_NUM_ENG-1:0]   req_i,
    input  logic [`CCU_NUM_ENG-1:0]   busy_i,
    input  logic [`CCU_NUM_ENG-1:0]   done_i,
    input  ccu_pkg::isa_addr_t        rd_ptr_i [`CCU_NUM_ENG],
    output logic [`CCU_NUM_ENG-1:0]   sel_o,
    output logic                      addr_fire_o,
    output logic                      dat_fire_o,
    output logic                      clear_o,
    // Network level
    output logic [`CCU_MODE_W-1:0]    mode_o,
    output logic                      net_done_o,
    output logic                      eng_rst_o
);
    import ccu_pkg::*;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_HDR  = 3'd1;
    localparam logic [2:0] S_ARB  = 3'd2;
    localparam logic [2:0] S_COLL = 3'd3;
    localparam logic [2:0] S_FIN  = 3'd4;

    logic [2:0]              state_q, state_d;
    logic                    pend_q;        // One read in flight
    logic [`CCU_NUM_ENG-1:0] sel_q;
    logic [`CCU_NUM_ENG-1:0] grant;
    logic [`CCU_LAYER_W-1:0] num_ly_q;
    logic [`CCU_LAYER_W-1:0] cfg_cnt_q;
    logic [`CCU_MODE_W-1:0]  mode_q;
    isa_addr_t               ptr_mux;
    logic                    hdr_fire;
    logic                    any_done;
    logic                    all_idle;
    logic                    cfg_done;

    // ======================================
    // FSM
    // ======================================
    assign any_done = |done_i;
    assign all_idle = ~|busy_i;
    assign cfg_done = (cfg_cnt_q == num_ly_q);
    assign hdr_fire = dat_fire_o & (state_q == S_HDR);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: if (start_i) state_d = S_HDR;
            S_HDR:  if (hdr_fire) state_d = S_ARB;
            S_ARB: begin
                if (cfg_done) begin
                    if (all_idle) state_d = S_FIN;   // Last one accepted
                end else if (|req_i) begin
                    state_d = S_COLL;
                end
            end
            S_COLL: if (any_done) state_d = S_ARB;
            S_FIN:  state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Lowest requesting index wins
    assign grant = req_i & (~req_i + 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (state_q == S_ARB && state_d == S_COLL) begin
            sel_q <= grant;
        end
    end

    assign sel_o = (state_q == S_COLL) ? sel_q : '0;

    // ======================================
    // Instruction RAM handshakes
    // ======================================
    always_comb begin
        ptr_mux = '0;
        for (int k = 0; k < `CCU_NUM_ENG; k++) begin
            if (sel_q[k]) ptr_mux = ptr_mux | rd_ptr_i[k];
        end
    end

    assign isa_addr_o     = (state_q == S_COLL) ? ptr_mux : '0;   // Header sits at 0
    assign isa_addr_vld_o = (state_q == S_HDR || state_q == S_COLL) && !pend_q;
    assign isa_dat_rdy_o  = pend_q;
    assign addr_fire_o    = isa_addr_vld_o & isa_addr_rdy_i;
    assign dat_fire_o     = isa_dat_vld_i & isa_dat_rdy_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else if (addr_fire_o) begin
            pend_q <= 1'b1;
        end else if (dat_fire_o) begin
            pend_q <= 1'b0;
        end
    end

    // Header decode and configuration count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_ly_q <= '0;
            mode_q   <= '0;
        end else if (hdr_fire) begin
            num_ly_q <= isa_dat_i.hdr.layers;
            mode_q   <= isa_dat_i.hdr.mode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_cnt_q <= '0;
        end else if (state_q == S_IDLE) begin
            cfg_cnt_q <= '0;
        end else if (state_q == S_COLL && any_done) begin
            cfg_cnt_q <= cfg_cnt_q + 1'b1;
        end
    end

    assign mode_o     = mode_q;
    assign net_done_o = (state_q == S_FIN);
    assign clear_o    = (state_q == S_IDLE);
    assign eng_rst_o  = (state_q == S_IDLE);   // Engines held while idle

endmodule

// ==== design/ccu_pkg.sv ====
`include "ccu_consts.svh"

package ccu_pkg;

    typedef logic [`CCU_ADDR_W-1:0]    isa_addr_t;
    typedef logic [`CCU_PAYLOAD_W-1:0] payload_t;

    // Word 0 in the low bits
    typedef payload_t [`CCU_CFG_WORDS-1:0] cfg_dat_t;

    // Header view, opcode 0
    typedef struct packed {
        logic [`CCU_HDR_RSV_W-1:0] rsvd;
        logic [`CCU_LAYER_W-1:0]   layers;   // Configurations in the network
        logic [`CCU_MODE_W-1:0]    mode;
        logic [`CCU_OPC_W-1:0]     opcode;   // Low byte in both views
    } isa_hdr_t;

    // Engine word view
    typedef struct packed {
        payload_t                  payload;
        logic [`CCU_OPC_W-1:0]     opcode;
    } isa_body_t;

    typedef union packed {
        isa_hdr_t  hdr;
        isa_body_t body;
    } isa_word_u;

endpackage

// ==== design/ccu_slot.sv ====
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_slot #(
    parameter int ENG_ID    = 1,
    parameter int NUM_WORDS = `CCU_CFG_WORDS
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear_i,
    input  logic                 sel_i,
    input  logic                 addr_fire_i,
    input  logic                 dat_fire_i,
    input  ccu_pkg::isa_word_u   dat_i,
    input  logic                 cfg_rdy_i,
    output logic                 req_o,
    output ccu_pkg::isa_addr_t   rd_ptr_o,
    output logic                 done_o,
    output logic                 busy_o,
    output logic                 cfg_vld_o,
    output ccu_pkg::cfg_dat_t    cfg_dat_o
);
    import ccu_pkg::*;

    localparam int CNT_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam logic [`CCU_OPC_W-1:0] MY_OPC = ENG_ID[`CCU_OPC_W-1:0];

    isa_addr_t        rd_ptr_q;
    logic [CNT_W-1:0] wcnt_q;
    logic             vld_q;
    cfg_dat_t         cfg_q;
    logic             hit;
    logic             last;

    // ======================================
    // Read pointer
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= isa_addr_t'(1);   // Address 0 holds the header
        end else if (clear_i) begin
            rd_ptr_q <= isa_addr_t'(1);
        end else if (sel_i && addr_fire_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // Matching words only
    assign hit  = sel_i & dat_fire_i & (dat_i.body.opcode == MY_OPC);
    assign last = hit & (wcnt_q == CNT_W'(NUM_WORDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wcnt_q <= '0;
        end else if (clear_i) begin
            wcnt_q <= '0;
        end else if (hit) begin
            wcnt_q <= last ? '0 : wcnt_q + 1'b1;
        end
    end

    // Stable while valid, no new collection starts until accepted
    always_ff @(posedge clk) begin
        if (hit) begin
            cfg_q[wcnt_q] <= dat_i.body.payload;
        end
    end

    // ======================================
    // Engine handshake
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (clear_i) begin
            vld_q <= 1'b0;
        end else if (vld_q && cfg_rdy_i) begin
            vld_q <= 1'b0;
        end else if (last) begin
            vld_q <= 1'b1;
        end
    end

    assign req_o     = cfg_rdy_i & ~vld_q;   // Ready engine, nothing pending
    assign done_o    = last;
    assign busy_o    = vld_q;
    assign cfg_vld_o = vld_q;
    assign cfg_dat_o = cfg_q;
    assign rd_ptr_o  = rd_ptr_q;

endmodule

// ==== design/ccu_top.sv ====
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    output logic                      net_done_o,
    output logic [`CCU_MODE_W-1:0]    mode_o,
    output logic                      eng_rst_o,
    // Instruction RAM
    output ccu_pkg::isa_addr_t        isa_addr_o,
    output logic                      isa_addr_vld_o,
    input  logic                      isa_addr_rdy_i,
    input  ccu_pkg::isa_word_u        isa_dat_i,
    input  logic                      isa_dat_vld_i,
    output logic                      isa_dat_rdy_o,
    output ccu_pkg::isa_addr_t        isa_min_addr_o,
    // Engines
    output logic [`CCU_NUM_ENG-1:0]   eng_cfg_vld_o,
    input  logic [`CCU_NUM_ENG-1:0]   eng_cfg_rdy_i,
    output ccu_pkg::cfg_dat_t         eng_cfg_dat_o [`CCU_NUM_ENG]
);
    import ccu_pkg::*;

    logic [`CCU_NUM_ENG-1:0] req;
    logic [`CCU_NUM_ENG-1:0] busy;
    logic [`CCU_NUM_ENG-1:0] done;
    logic [`CCU_NUM_ENG-1:0] sel;
    isa_addr_t               rd_ptr [`CCU_NUM_ENG];
    logic                    addr_fire;
    logic                    dat_fire;
    logic                    clear;

    // ======================================
    // Fetch sequencer
    // ======================================
    ccu_fetch u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .isa_addr_o     (isa_addr_o),
        .isa_addr_vld_o (isa_addr_vld_o),
        .isa_addr_rdy_i (isa_addr_rdy_i),
        .isa_dat_i      (isa_dat_i),
        .isa_dat_vld_i  (isa_dat_vld_i),
        .isa_dat_rdy_o  (isa_dat_rdy_o),
        .req_i          (req),
        .busy_i         (busy),
        .done_i         (done),
        .rd_ptr_i       (rd_ptr),
        .sel_o          (sel),
        .addr_fire_o    (addr_fire),
        .dat_fire_o     (dat_fire),
        .clear_o        (clear),
        .mode_o         (mode_o),
        .net_done_o     (net_done_o),
        .eng_rst_o      (eng_rst_o)
    );

    // One slot per engine, opcode = index + 1
    for (genvar g = 0; g < `CCU_NUM_ENG; g++) begin : g_slot
        ccu_slot #(
            .ENG_ID (g + 1)
        ) u_slot (
            .clk         (clk),
            .rst_n       (rst_n),
            .clear_i     (clear),
            .sel_i       (sel[g]),
            .addr_fire_i (addr_fire),
            .dat_fire_i  (dat_fire),
            .dat_i       (isa_dat_i),   // Shared read data bus
            .cfg_rdy_i   (eng_cfg_rdy_i[g]),
            .req_o       (req[g]),
            .rd_ptr_o    (rd_ptr[g]),
            .done_o      (done[g]),
            .busy_o      (busy[g]),
            .cfg_vld_o   (eng_cfg_vld_o[g]),
            .cfg_dat_o   (eng_cfg_dat_o[g])
        );
    end

    ccu_addr_min u_addr_min (
        .rd_ptr_i (rd_ptr),
        .min_o    (isa_min_addr_o)
    );

endmodule

// ==== src.f ====
+incdir+design
design/ccu_pkg.sv
design/ccu_addr_min.sv
design/ccu_slot.sv
design/ccu_fetch.sv
design/ccu_top.sv
tests/ccu_assertions.sv
tests/ccu_checker.sv
tests/tb_ccu.sv

// ==== tests/ccu_assertions.sv ====
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_assertions (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    addr_vld_i,
    input  logic                    addr_rdy_i,
    input  logic                    dat_vld_i,
    input  logic                    dat_rdy_i,
    input  logic                    net_done_i,
    input  logic                    eng_rst_i,
    input  logic [`CCU_NUM_ENG-1:0] cfg_vld_i,
    input  logic [`CCU_NUM_ENG-1:0] cfg_rdy_i,
    input  ccu_pkg::cfg_dat_t       cfg_dat_i [`CCU_NUM_ENG]
);
    import ccu_pkg::*;

    logic rd_pend_q;   // Address accepted, data not yet
    int   fail_cnt;    // Failed assertions, read by the testbench

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
        end else if (addr_vld_i && addr_rdy_i) begin
            rd_pend_q <= 1'b1;
        end else if (dat_vld_i && dat_rdy_i) begin
            rd_pend_q <= 1'b0;
        end
    end

    // ======================================
    // Reset and idle rules
    // ======================================
    a_rst_state: assert property (@(posedge clk)
        !rst_n |-> eng_rst_i && !addr_vld_i && !dat_rdy_i && !net_done_i)
        else begin
            $error("DUT outputs not in reset state");
            fail_cnt++;
        end

    a_idle_quiet: assert property (@(posedge clk)
        eng_rst_i |-> (cfg_vld_i == '0))
        else begin
            $error("configuration valid high while engines held in reset");
            fail_cnt++;
        end

    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pend_q |-> !addr_vld_i)
        else begin
            $error("address offered while a read is outstanding");
            fail_cnt++;
        end

    for (genvar g = 0; g < `CCU_NUM_ENG; g++) begin : g_hold
        a_cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
            cfg_vld_i[g] && !cfg_rdy_i[g] |=> cfg_vld_i[g] && $stable(cfg_dat_i[g]))
            else begin
                $error("configuration dropped or changed while waiting for ready");
                fail_cnt++;
            end
    end

endmodule

bind ccu_top ccu_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_vld_i (isa_addr_vld_o),
    .addr_rdy_i (isa_addr_rdy_i),
    .dat_vld_i  (isa_dat_vld_i),
    .dat_rdy_i  (isa_dat_rdy_o),
    .net_done_i (net_done_o),
    .eng_rst_i  (eng_rst_o),
    .cfg_vld_i  (eng_cfg_vld_o),
    .cfg_rdy_i  (eng_cfg_rdy_i),
    .cfg_dat_i  (eng_cfg_dat_o)
);

// ==== tests/ccu_checker.sv ====
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic                    addr_vld_i,
    input  logic                    net_done_i,
    input  logic [`CCU_MODE_W-1:0]  mode_i,
    input  logic                    eng_rst_i,
    input  logic [`CCU_NUM_ENG-1:0] cfg_vld_i,
    input  logic [`CCU_NUM_ENG-1:0] cfg_rdy_i,
    input  ccu_pkg::cfg_dat_t       cfg_dat_i [`CCU_NUM_ENG],
    input  ccu_pkg::isa_addr_t      min_addr_i,
    output int                      err_cnt_o,
    output int                      done_cnt_o
);
    import ccu_pkg::*;

    logic [63:0]             tmem [0:127];
    int                      acc [`CCU_NUM_ENG] = '{default: 0};   // Accepted configurations
    int                      col [`CCU_NUM_ENG] = '{default: 0};   // Collected, by valid rise
    logic [`CCU_NUM_ENG-1:0] vld_q = '0;
    logic                    started = 1'b0;
    int                      err_cnt = 0;
    int                      done_cnt = 0;

    initial $readmemh("tests/ccu_tests.hex", tmem);

    function automatic int cfg_count(input int k);
        logic [6:0] idx;
        idx = 7'(48 + k);
        return int'(tmem[idx][31:0]);
    endfunction

    function automatic logic [6:0] exp_index(input int k, input int j, input int w);
        return 7'(64 + k * 8 + j * `CCU_CFG_WORDS + w);
    endfunction

    // Address of the last word of configuration j, from the top byte
    function automatic int last_word_addr(input int k, input int j);
        return int'(tmem[exp_index(k, j, `CCU_CFG_WORDS - 1)][63:56]);
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // ======================================
    // Port monitor
    // ======================================
    always @(posedge clk) begin
        cfg_dat_t exp_dat;
        int       bound;
        int       sum;
        if (rst_n) begin
            if (start_i) started = 1'b1;
            if (!started && (cfg_vld_i != '0 || addr_vld_i || net_done_i || !eng_rst_i)) begin
                report_error("outputs left their reset values before start");
            end
            bound = 1 << `CCU_ADDR_W;
            for (int k = 0; k < `CCU_NUM_ENG; k++) begin
                if (col[k] < cfg_count(k) && last_word_addr(k, col[k]) + 1 < bound) begin
                    bound = last_word_addr(k, col[k]) + 1;
                end
            end
            if (int'(min_addr_i) > bound) begin
                report_error($sformatf("isa_min_addr_o %0d above bound %0d", min_addr_i, bound));
            end
            for (int k = 0; k < `CCU_NUM_ENG; k++) begin
                if (cfg_vld_i[k] && !vld_q[k]) col[k]++;
                if (cfg_vld_i[k] && cfg_rdy_i[k]) begin
                    if (acc[k] >= cfg_count(k)) begin
                        report_error($sformatf("engine %0d got an extra configuration", k));
                    end else begin
                        for (int w = 0; w < `CCU_CFG_WORDS; w++) begin
                            exp_dat[w] = tmem[exp_index(k, acc[k], w)][`CCU_PAYLOAD_W-1:0];
                        end
                        if (cfg_dat_i[k] !== exp_dat) begin
                            report_error($sformatf("engine %0d cfg %0d is %h, expected %h",
                                k, acc[k], cfg_dat_i[k], exp_dat));
                        end
                    end
                    acc[k]++;
                end
            end
            vld_q = cfg_vld_i;
            if (net_done_i) begin
                done_cnt++;
                sum = 0;
                for (int k = 0; k < `CCU_NUM_ENG; k++) sum += acc[k];
                if (done_cnt != 1) report_error("net_done_o pulsed more than once");
                if (sum != int'(tmem[0][31:16])) begin
                    report_error($sformatf("net_done_o after %0d accepted, layer count %0d",
                        sum, tmem[0][31:16]));
                end
                if (mode_i !== tmem[0][15:8]) begin
                    report_error($sformatf("mode_o %h, expected %h", mode_i, tmem[0][15:8]));
                end
            end
        end
    end

    assign err_cnt_o  = err_cnt;
    assign done_cnt_o = done_cnt;

endmodule

// ==== tests/ccu_tests.hex ====
// Words 00..10: instruction RAM image, header first. 30..33: configurations per engine.
// 38: image length. 40 + 8*engine + word: expected payload word, top byte = its address.
@000
0000000000065A00
D1005A5A5A5A5A01
D2005A5A5A5A5A02
123456789ABCDE07
D1015A5A5A5A5A01
D3005A5A5A5A5A03
D2015A5A5A5A5A02
FFFFFFFFFFFFFF00
D4005A5A5A5A5A04
D1105A5A5A5A5A01
D3015A5A5A5A5A03
0F0F0F0F0F0F0F05
D2105A5A5A5A5A02
D1115A5A5A5A5A01
D4015A5A5A5A5A04
D2115A5A5A5A5A02
C3C3C3C3C3C3C32A
@030
0000000000000002
0000000000000002
0000000000000001
0000000000000001
@038
0000000000000011
@040
01D1005A5A5A5A5A
04D1015A5A5A5A5A
09D1105A5A5A5A5A
0DD1115A5A5A5A5A
@048
02D2005A5A5A5A5A
06D2015A5A5A5A5A
0CD2105A5A5A5A5A
0FD2115A5A5A5A5A
@050
05D3005A5A5A5A5A
0AD3015A5A5A5A5A
@058
08D4005A5A5A5A5A
0ED4015A5A5A5A5A

// ==== tests/tb_ccu.sv ====
`timescale 1ns/1ps
`include "ccu_consts.svh"

module tb_ccu;
    import ccu_pkg::*;

    logic                    clk;
    logic                    rst_n;
    logic                    start_i;
    logic                    net_done_o;
    logic [`CCU_MODE_W-1:0]  mode_o;
    logic                    eng_rst_o;
    isa_addr_t               isa_addr_o;
    logic                    isa_addr_vld_o;
    logic                    isa_addr_rdy_i;
    isa_word_u               isa_dat_i;
    logic                    isa_dat_vld_i;
    logic                    isa_dat_rdy_o;
    isa_addr_t               isa_min_addr_o;
    logic [`CCU_NUM_ENG-1:0] eng_cfg_vld_o;
    logic [`CCU_NUM_ENG-1:0] eng_cfg_rdy_i;
    cfg_dat_t                eng_cfg_dat_o [`CCU_NUM_ENG];

    logic [63:0] tmem [0:127];
    integer      seed = 1;
    int          acc [`CCU_NUM_ENG] = '{default: 0};
    logic        addr_seen = 1'b0;
    logic        dat_seen = 1'b0;
    isa_addr_t   addr_q = '0;
    int          err_cnt;
    int          done_cnt;

    ccu_top dut (.*);

    ccu_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .addr_vld_i (isa_addr_vld_o),
        .net_done_i (net_done_o),
        .mode_i     (mode_o),
        .eng_rst_i  (eng_rst_o),
        .cfg_vld_i  (eng_cfg_vld_o),
        .cfg_rdy_i  (eng_cfg_rdy_i),
        .cfg_dat_i  (eng_cfg_dat_o),
        .min_addr_i (isa_min_addr_o),
        .err_cnt_o  (err_cnt),
        .done_cnt_o (done_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    function automatic int image_len();
        return int'(tmem[7'h38][31:0]);
    endfunction

    function automatic int cfg_count(input int k);
        return int'(tmem[7'(48 + k)][31:0]);
    endfunction

    function automatic logic [63:0] read_image(input isa_addr_t a);
        if (int'(a) < image_len()) return tmem[a[6:0]];
        return '0;
    endfunction

    // Handshakes seen at the clock edge, acted on at the falling edge
    always @(posedge clk) begin
        addr_seen <= isa_addr_vld_o && isa_addr_rdy_i;
        dat_seen  <= isa_dat_vld_i && isa_dat_rdy_o;
        if (isa_addr_vld_o && isa_addr_rdy_i) addr_q <= isa_addr_o;
        for (int k = 0; k < `CCU_NUM_ENG; k++) begin
            if (eng_cfg_vld_o[k] && eng_cfg_rdy_i[k]) acc[k] <= acc[k] + 1;
        end
    end

    // ======================================
    // RAM and engine models
    // ======================================
    initial begin : ram_engine_model
        logic      pend;
        isa_addr_t raddr;
        pend           = 1'b0;
        raddr          = '0;
        isa_addr_rdy_i = 1'b0;
        isa_dat_vld_i  = 1'b0;
        isa_dat_i      = '0;
        eng_cfg_rdy_i  = '0;
        forever begin
            @(negedge clk);
            if (addr_seen) begin
                pend  = 1'b1;
                raddr = addr_q;
            end
            if (dat_seen) begin
                pend          = 1'b0;
                isa_dat_vld_i = 1'b0;
            end
            if (pend && !isa_dat_vld_i && (($random(seed) & 3) != 0)) begin
                isa_dat_vld_i = 1'b1;
                isa_dat_i     = read_image(raddr);
            end
            isa_addr_rdy_i = !pend && (($random(seed) & 3) != 0);
            for (int k = 0; k < `CCU_NUM_ENG; k++) begin
                // Engine stops asking once all its configurations are in
                eng_cfg_rdy_i[k] = (acc[k] < cfg_count(k)) && (($random(seed) & 1) != 0);
            end
        end
    end

    task automatic wait_net_done();
        do begin
            @(posedge clk);
        end while (!net_done_o);
    endtask

    initial begin : watchdog
        int limit_ns;
        #1;
        limit_ns = (image_len() * `CCU_NUM_ENG * 30 + 100) * 20;
        #(limit_ns);
        $display("Timeout: net_done_o did not pulse within %0d ns", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        rst_n   = 1'b0;
        start_i = 1'b0;
        $readmemh("tests/ccu_tests.hex", tmem);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        wait_net_done();
        repeat (10) @(negedge clk);   // Catch a second pulse
        $display("Checker errors: %0d, assertion failures: %0d, net_done_o pulses: %0d",
            err_cnt, dut.u_assertions.fail_cnt, done_cnt);
        if (err_cnt == 0 && dut.u_assertions.fail_cnt == 0 && done_cnt == 1) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
